// File: tb.f
hdl/rvv_cfg_pkg.sv
hdl/rvv_types_pkg.sv
hdl/multi_fifo.sv
hdl/rvv_backend_dispatch.sv
hdl/rvv_backend_alu.sv
hdl/rvv_backend_rob.sv
hdl/rvv_backend_vrf.sv
hdl/rvv_backend.sv
bench/tb_clock.sv
bench/rvv_backend_assertions.sv
bench/tb_rvv_backend.sv

// File: bench/tb_rvv_backend.sv
`timescale 1ns/1ps

module tb_rvv_backend
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
();

  typedef enum int {
    BP_OPEN,
    BP_RANDOM,
    BP_HOLD
  } bp_mode_e;

  localparam int WAIT_LIMIT = 400;

  logic                      clk;
  logic                      rst_n;
  logic [ISSUE_LANE-1:0]     insts_valid;
  rvv_cmd_t [ISSUE_LANE-1:0] insts;
  logic [ISSUE_LANE-1:0]     insts_ready;
  logic                      rt_valid;
  rt_data_t                  rt_data;
  logic                      rt_ready;

  logic [VLEN-1:0]  ref_vrf [NUM_VREG];
  rt_data_t         exp_q [$];
  rvv_cmd_t         send_q [$];
  bp_mode_e         bp_mode;
  logic [TAG_W-1:0] next_tag;
  int               accepted_cnt;
  int               retired_cnt;
  int               dual_cnt;
  int               check_cnt;
  int               error_cnt;
  int               cycle;
  int               accept_cycle;
  int               retire_cycle;
  bit               aborted;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rvv_backend rvv_backend_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .insts_valid (insts_valid),
    .insts       (insts),
    .insts_ready (insts_ready),
    .rt_valid    (rt_valid),
    .rt_data     (rt_data),
    .rt_ready    (rt_ready)
  );

  bind rvv_backend rvv_backend_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .insts_valid (insts_valid),
    .insts_ready (insts_ready),
    .rt_valid    (rt_valid),
    .rt_data     (rt_data),
    .rt_ready    (rt_ready)
  );

  // Register file model with vd = vs2 op vs1 per byte mod 256
  function automatic rt_data_t ref_execute(input rvv_cmd_t cmd);
    rt_data_t   r;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] y;
    r.tag = cmd.tag;
    r.vd  = cmd.vd;
    for (int e = 0; e < NUM_ELEM; e++) begin
      a = ref_vrf[cmd.vs2][e*8 +: 8];
      b = ref_vrf[cmd.vs1][e*8 +: 8];
      case (cmd.funct)
        FN_ADD: y = a + b;
        FN_SUB: y = a - b;
        FN_AND: y = a & b;
        FN_XOR: y = a ^ b;
      endcase
      r.data[e*8 +: 8] = y;
    end
    ref_vrf[cmd.vd] = r.data;
    return r;
  endfunction

  function automatic rvv_cmd_t make_cmd(input alu_funct_e funct, input int vd,
                                        input int vs1, input int vs2);
    rvv_cmd_t c;
    c.tag    = next_tag;
    c.funct  = funct;
    c.vd     = VREG_IDX_W'(vd);
    c.vs1    = VREG_IDX_W'(vs1);
    c.vs2    = VREG_IDX_W'(vs2);
    next_tag = next_tag + 1'b1;
    return c;
  endfunction

  function automatic rvv_cmd_t random_cmd();
    int funct;
    int vd;
    int vs1;
    int vs2;
    funct = $urandom % 4;
    vd    = $urandom % NUM_VREG;
    vs1   = $urandom % NUM_VREG;
    vs2   = $urandom % NUM_VREG;
    return make_cmd(alu_funct_e'(funct), vd, vs1, vs2);
  endfunction

  task automatic check_rt_data(input rt_data_t got, input rt_data_t want);
    check_cnt++;
    if (got !== want) begin
      error_cnt++;
      $display("[ERROR] %0t: retired tag %0d vd %0d data %h, expected tag %0d vd %0d data %h",
               $time, got.tag, got.vd, got.data, want.tag, want.vd, want.data);
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    check_cnt++;
    if (got != want) begin
      error_cnt++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic report_timeout(input string what);
    error_cnt++;
    aborted = 1'b1;
    $display("Timeout: gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
  endtask

  // One rising edge, with rt_ready set for the next cycle
  task automatic tick();
    @(posedge clk);
    case (bp_mode)
      BP_OPEN:   rt_ready <= 1'b1;
      BP_RANDOM: rt_ready <= (($urandom % 4) != 0);
      default:   rt_ready <= 1'b0;
    endcase
  endtask

  // Both lanes used whenever two commands wait
  task automatic drive_cmds();
    int waited;
    waited = 0;
    tick();
    while (send_q.size() > 0 && waited < WAIT_LIMIT) begin
      insts_valid[0] <= 1'b1;
      insts[0]       <= send_q[0];
      insts_valid[1] <= (send_q.size() > 1);
      if (send_q.size() > 1) begin
        insts[1] <= send_q[1];
      end
      tick();
      waited++;
      if (insts_ready[0]) begin
        send_q.delete(0);
        waited = 0;
        if (insts_valid[1] && insts_ready[1]) begin
          send_q.delete(0);
        end
      end
    end
    insts_valid <= '0;
    if (send_q.size() > 0) begin
      report_timeout("the intake to accept a command");
      send_q.delete();
    end
  endtask

  // Counters are read at the falling edge after the monitor has run
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (retired_cnt != accepted_cnt && waited < WAIT_LIMIT) begin
      tick();
      @(negedge clk);
      waited++;
    end
    if (retired_cnt != accepted_cnt) begin
      report_timeout("all accepted instructions to retire");
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_start);
    $display("Test %0d %s: %0d errors", num, name, error_cnt - err_start);
  endtask

  task automatic issue_and_retire(input rvv_cmd_t cmd);
    send_q.push_back(cmd);
    drive_cmds();
    wait_drain();
    check_count("intake to retire latency", retire_cycle - accept_cycle, 4);
  endtask

  task automatic all_functions();
    int err_start;
    err_start = error_cnt;
    issue_and_retire(make_cmd(FN_ADD, 0, 1, 2));
    issue_and_retire(make_cmd(FN_SUB, 3, 4, 5));
    issue_and_retire(make_cmd(FN_AND, 6, 1, 4));
    issue_and_retire(make_cmd(FN_XOR, 7, 2, 5));
    end_test(1, "all functions", err_start);
  endtask

  // Each command reads the previous destination through vs1
  task automatic dependent_chain();
    int err_start;
    err_start = error_cnt;
    for (int i = 0; i < 12; i++) begin
      send_q.push_back(make_cmd(alu_funct_e'(i % 4), (i + 1) % 8, i % 8, (i + 5) % 8));
    end
    drive_cmds();
    wait_drain();
    end_test(2, "dependent chain", err_start);
  endtask

  task automatic dual_lane();
    int err_start;
    int dual_start;
    err_start  = error_cnt;
    dual_start = dual_cnt;
    for (int i = 0; i < 8; i++) begin
      send_q.push_back(random_cmd());
    end
    drive_cmds();
    wait_drain();
    if (dual_cnt == dual_start) begin
      error_cnt++;
      $display("[ERROR] %0t: no cycle accepted both intake lanes", $time);
    end
    end_test(3, "dual lane", err_start);
  endtask

  task automatic random_traffic();
    int err_start;
    err_start = error_cnt;
    bp_mode   = BP_RANDOM;
    for (int b = 0; b < 30 && !aborted; b++) begin
      send_q.push_back(random_cmd());
      if (($urandom % 2) != 0) begin
        send_q.push_back(random_cmd());
      end
      drive_cmds();
      repeat ($urandom % 3) tick();
    end
    wait_drain();
    bp_mode = BP_OPEN;
    end_test(4, "random back-pressure", err_start);
  endtask

  task automatic long_hold();
    int err_start;
    int waited;
    err_start = error_cnt;
    waited    = 0;
    bp_mode   = BP_HOLD;
    tick();
    insts_valid[0] <= 1'b1;
    insts[0]       <= random_cmd();
    tick();
    while (insts_ready[0] && waited < WAIT_LIMIT) begin
      insts[0] <= random_cmd();
      tick();
      waited++;
    end
    insts_valid[0] <= 1'b0;
    if (insts_ready[0]) begin
      report_timeout("insts_ready to fall while rt_ready is held low");
    end
    repeat (30) tick();
    check_count("insts_ready during hold", insts_ready[0], 0);
    bp_mode = BP_OPEN;
    wait_drain();
    end_test(5, "long retire hold", err_start);
  endtask

  // Monitor for intake acceptance and retirement
  always @(posedge clk) begin
    rt_data_t want;
    cycle++;
    if (rst_n) begin
      if (insts_valid[0] && insts_ready[0]) begin
        exp_q.push_back(ref_execute(insts[0]));
        accepted_cnt++;
        accept_cycle = cycle;
      end
      if (insts_valid[1] && insts_ready[1]) begin
        exp_q.push_back(ref_execute(insts[1]));
        accepted_cnt++;
        dual_cnt++;
      end
      if (rt_valid && rt_ready) begin
        retired_cnt++;
        retire_cycle = cycle;
        if (exp_q.size() == 0) begin
          error_cnt++;
          $display("[ERROR] %0t: tag %0d retired with nothing outstanding", $time, rt_data.tag);
        end else begin
          want = exp_q.pop_front();
          check_rt_data(rt_data, want);
        end
      end
    end
  end

  initial begin
    int waited;
    void'($urandom(29947));
    insts_valid  = '0;
    insts        = '0;
    rt_ready     = 1'b1;
    bp_mode      = BP_OPEN;
    next_tag     = '0;
    accepted_cnt = 0;
    retired_cnt  = 0;
    dual_cnt     = 0;
    check_cnt    = 0;
    error_cnt    = 0;
    cycle        = 0;
    accept_cycle = 0;
    retire_cycle = 0;
    aborted      = 1'b0;
    // Register r, element e starts as 8r + e
    for (int r = 0; r < NUM_VREG; r++) begin
      for (int e = 0; e < NUM_ELEM; e++) begin
        ref_vrf[r][e*8 +: 8] = 8'(8 * r + e);
      end
    end
    waited = 0;
    while (!rst_n && waited < WAIT_LIMIT) begin
      tick();
      waited++;
    end
    if (!rst_n) begin
      report_timeout("reset to be released");
    end
    if (!aborted) all_functions();
    if (!aborted) dependent_chain();
    if (!aborted) dual_lane();
    if (!aborted) random_traffic();
    if (!aborted) long_hold();
    check_count("retired count against accepted count", retired_cnt, accepted_cnt);
    error_cnt += rvv_backend_inst.u_assertions.assert_fails;
    $display("Accepted %0d, retired %0d, checks %0d, errors %0d",
             accepted_cnt, retired_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: bench/rvv_backend_assertions.sv
`timescale 1ns/1ps

module rvv_backend_assertions
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic [ISSUE_LANE-1:0] insts_valid,
  input logic [ISSUE_LANE-1:0] insts_ready,
  input logic                  rt_valid,
  input rt_data_t              rt_data,
  input logic                  rt_ready
);

  int assert_fails;

  // Lane 1 only transfers together with lane 0
  lane_prefix: assert property (@(posedge clk) disable iff (!rst_n)
    (insts_valid[1] && insts_ready[1]) |-> (insts_valid[0] && insts_ready[0]))
    else begin
      $error("intake lane 1 transferred without lane 0");
      assert_fails++;
    end

  // Retire port holds its offer until taken
  retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && !rt_ready) |=> (rt_valid && $stable(rt_data)))
    else begin
      $error("retire port dropped or changed an offer before rt_ready");
      assert_fails++;
    end

  // From the second reset edge on, so registered state is known
  reset_quiet: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (insts_ready == '0 && !rt_valid))
    else begin
      $error("insts_ready or rt_valid active during reset");
      assert_fails++;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: hdl/rvv_backend.sv
`timescale 1ns/1ps

module rvv_backend
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [ISSUE_LANE-1:0]      insts_valid,
  input  rvv_cmd_t [ISSUE_LANE-1:0]  insts,
  output logic [ISSUE_LANE-1:0]      insts_ready,
  output logic                       rt_valid,
  output rt_data_t                   rt_data,
  input  logic                       rt_ready
);

  logic                         cq_full;
  logic                         cq_almost_full;
  logic                         cq_empty;
  logic                         cq_pop;
  rvv_cmd_t                     cq_cmd;
  logic                         rs_valid;
  logic                         rs_full;
  logic                         rs_empty;
  logic                         rs_pop;
  alu_uop_t                     dp_uop;
  alu_uop_t                     rs_uop;
  logic                         rob_alloc;
  logic                         rob_ready;
  logic [TAG_W-1:0]             rob_tag;
  logic [VREG_IDX_W-1:0]        rob_vd;
  logic [ROB_IDX_W-1:0]         rob_index;
  rob_pending_t [ROB_DEPTH-1:0] rob_pending;
  logic [1:0][VREG_IDX_W-1:0]   rd_index;
  logic [1:0][VLEN-1:0]         rd_data;
  logic                         res_valid;
  logic                         res_ready;
  pu2rob_t                      res;
  logic                         vrf_we;
  rt_data_t                     vrf_wr;

  // Lane 1 needs two free slots on top of lane 0 being ready
  assign insts_ready[0] = !cq_full;
  assign insts_ready[1] = !cq_full && !cq_almost_full;

  multi_fifo #(
    .T     (rvv_cmd_t),
    .M     (ISSUE_LANE),
    .N     (1),
    .DEPTH (CQ_DEPTH)
  ) u_command_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (insts_valid & insts_ready),
    .datain       (insts),
    .pop          (cq_pop),
    .dataout      (cq_cmd),
    .full         (cq_full),
    .almost_full  (cq_almost_full),
    .empty        (cq_empty),
    .almost_empty ()
  );

  rvv_backend_dispatch u_dispatch (
    .cmd         (cq_cmd),
    .cmd_empty   (cq_empty),
    .cmd_pop     (cq_pop),
    .rs_valid    (rs_valid),
    .rs_uop      (dp_uop),
    .rs_ready    (!rs_full),
    .rob_alloc   (rob_alloc),
    .rob_tag     (rob_tag),
    .rob_vd      (rob_vd),
    .rob_ready   (rob_ready),
    .rob_index   (rob_index),
    .rob_pending (rob_pending),
    .rd_index    (rd_index),
    .rd_data     (rd_data)
  );

  multi_fifo #(
    .T     (alu_uop_t),
    .M     (1),
    .N     (1),
    .DEPTH (ALU_RS_DEPTH)
  ) u_alu_rs (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (rs_valid && !rs_full),
    .datain       (dp_uop),
    .pop          (rs_pop),
    .dataout      (rs_uop),
    .full         (rs_full),
    .almost_full  (),
    .empty        (rs_empty),
    .almost_empty ()
  );

  rvv_backend_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs_empty  (rs_empty),
    .rs_pop    (rs_pop),
    .rs_uop    (rs_uop),
    .res_valid (res_valid),
    .res       (res),
    .res_ready (res_ready)
  );

  rvv_backend_rob u_rob (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc       (rob_alloc),
    .alloc_tag   (rob_tag),
    .alloc_vd    (rob_vd),
    .alloc_ready (rob_ready),
    .alloc_index (rob_index),
    .wr_valid    (res_valid),
    .wr          (res),
    .wr_ready    (res_ready),
    .pending     (rob_pending),
    .rt_valid    (rt_valid),
    .rt_data     (rt_data),
    .rt_ready    (rt_ready),
    .vrf_we      (vrf_we),
    .vrf_wr      (vrf_wr)
  );

  rvv_backend_vrf u_vrf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .we       (vrf_we),
    .wr       (vrf_wr)
  );

endmodule

// File: hdl/rvv_backend_vrf.sv
`timescale 1ns/1ps

module rvv_backend_vrf
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [1:0][VREG_IDX_W-1:0] rd_index,
  output logic [1:0][VLEN-1:0]       rd_data,
  input  logic                       we,
  input  rt_data_t                   wr
);

  logic [VLEN-1:0] regs [NUM_VREG];

  // Known start state, element e of register r holds NUM_ELEM*r + e
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_VREG; r++) begin
        for (int e = 0; e < NUM_ELEM; e++) begin
          regs[r][e*SEW +: SEW] <= SEW'(NUM_ELEM * r + e);
        end
      end
    end else if (we) begin
      regs[wr.vd] <= wr.data;
    end
  end

  // Asynchronous read for dispatch
  assign rd_data[0] = regs[rd_index[0]];
  assign rd_data[1] = regs[rd_index[1]];

endmodule

// File: hdl/rvv_backend_rob.sv
`timescale 1ns/1ps

module rvv_backend_rob
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         alloc,
  input  logic [TAG_W-1:0]             alloc_tag,
  input  logic [VREG_IDX_W-1:0]        alloc_vd,
  output logic                         alloc_ready,
  output logic [ROB_IDX_W-1:0]         alloc_index,
  input  logic                         wr_valid,
  input  pu2rob_t                      wr,
  output logic                         wr_ready,
  output rob_pending_t [ROB_DEPTH-1:0] pending,
  output logic                         rt_valid,
  output rt_data_t                     rt_data,
  input  logic                         rt_ready,
  output logic                         vrf_we,
  output rt_data_t                     vrf_wr
);

  logic [ROB_DEPTH-1:0]  ent_valid;
  logic [ROB_DEPTH-1:0]  ent_done;
  logic [TAG_W-1:0]      ent_tag  [ROB_DEPTH];
  logic [VREG_IDX_W-1:0] ent_vd   [ROB_DEPTH];
  logic [VLEN-1:0]       ent_data [ROB_DEPTH];
  logic [ROB_IDX_W-1:0]  head;
  logic [ROB_IDX_W-1:0]  tail;
  logic                  do_alloc;
  logic                  do_write;
  logic                  do_retire;

  // Allocation is in order, so a busy tail means the buffer is full
  assign alloc_ready = !ent_valid[tail];
  assign alloc_index = tail;
  assign do_alloc    = alloc && alloc_ready;

  // One ALU, results are always taken
  assign wr_ready = 1'b1;
  assign do_write = wr_valid && wr_ready;

  assign rt_valid  = ent_valid[head] && ent_done[head];
  assign rt_data   = '{tag: ent_tag[head], vd: ent_vd[head], data: ent_data[head]};
  assign do_retire = rt_valid && rt_ready;

  // Retire and register-file write are the same event
  assign vrf_we = do_retire;
  assign vrf_wr = rt_data;

  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      pending[i].valid = ent_valid[i];
      pending[i].vd    = ent_vd[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
    end else begin
      if (do_alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (do_write) begin
        ent_done[wr.rob_idx] <= 1'b1;
      end
      if (do_retire) begin
        ent_valid[head] <= 1'b0;
        ent_done[head]  <= 1'b0;
        head            <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      ent_tag[tail] <= alloc_tag;
      ent_vd[tail]  <= alloc_vd;
    end
    if (do_write) begin
      ent_data[wr.rob_idx] <= wr.data;
    end
  end

endmodule

// File: hdl/rvv_backend_alu.sv
`timescale 1ns/1ps

module rvv_backend_alu
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rs_empty,
  output logic     rs_pop,
  input  alu_uop_t rs_uop,
  output logic     res_valid,
  output pu2rob_t  res,
  input  logic     res_ready
);

  logic [VLEN-1:0] result;

  // Take a new uop when the output slot is free or draining this cycle
  assign rs_pop = !rs_empty && (!res_valid || res_ready);

  // vd = vs2 op vs1 per element, wrapping at SEW bits
  always_comb begin
    logic [SEW-1:0] a;
    logic [SEW-1:0] b;
    for (int e = 0; e < NUM_ELEM; e++) begin
      a = rs_uop.vs2_data[e*SEW +: SEW];
      b = rs_uop.vs1_data[e*SEW +: SEW];
      unique case (rs_uop.funct)
        FN_ADD: result[e*SEW +: SEW] = a + b;
        FN_SUB: result[e*SEW +: SEW] = a - b;
        FN_AND: result[e*SEW +: SEW] = a & b;
        FN_XOR: result[e*SEW +: SEW] = a ^ b;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (rs_pop) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rs_pop) begin
      res.rob_idx <= rs_uop.rob_idx;
      res.data    <= result;
    end
  end

endmodule

// File: hdl/rvv_backend_dispatch.sv
`timescale 1ns/1ps

module rvv_backend_dispatch
  import rvv_cfg_pkg::*;
  import rvv_types_pkg::*;
(
  input  rvv_cmd_t                     cmd,
  input  logic                         cmd_empty,
  output logic                         cmd_pop,
  output logic                         rs_valid,
  output alu_uop_t                     rs_uop,
  input  logic                         rs_ready,
  output logic                         rob_alloc,
  output logic [TAG_W-1:0]             rob_tag,
  output logic [VREG_IDX_W-1:0]        rob_vd,
  input  logic                         rob_ready,
  input  logic [ROB_IDX_W-1:0]         rob_index,
  input  rob_pending_t [ROB_DEPTH-1:0] rob_pending,
  output logic [1:0][VREG_IDX_W-1:0]   rd_index,
  input  logic [1:0][VLEN-1:0]         rd_data
);

  logic hazard;
  logic issue;

  // No bypass, any in-flight writer of a source blocks the command
  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (rob_pending[i].valid &&
          (rob_pending[i].vd == cmd.vs1 || rob_pending[i].vd == cmd.vs2)) begin
        hazard = 1'b1;
      end
    end
  end

  assign issue = !cmd_empty && !hazard;

  // Station push, ROB allocate and queue pop all happen together
  assign rs_valid  = issue && rob_ready;
  assign rob_alloc = issue && rs_ready;
  assign cmd_pop   = issue && rs_ready && rob_ready;

  assign rob_tag = cmd.tag;
  assign rob_vd  = cmd.vd;

  // Port 0 reads vs1, port 1 reads vs2
  assign rd_index[0] = cmd.vs1;
  assign rd_index[1] = cmd.vs2;

  always_comb begin
    rs_uop.rob_idx  = rob_index;
    rs_uop.funct    = cmd.funct;
    rs_uop.vs1_data = rd_data[0];
    rs_uop.vs2_data = rd_data[1];
  end

endmodule

// File: hdl/multi_fifo.sv
`timescale 1ns/1ps

module multi_fifo #(
  parameter type T     = logic [7:0],
  parameter int  M     = 1,
  parameter int  N     = 1,
  parameter int  DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [M-1:0] push,
  input  T     [M-1:0] datain,
  input  logic [N-1:0] pop,
  output T     [N-1:0] dataout,
  output logic         full,
  output logic         almost_full,
  output logic         empty,
  output logic         almost_empty
);

  // DEPTH is a power of two, pointers wrap on their own
  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [CW-1:0] count;
  logic [CW-1:0] push_cnt;
  logic [CW-1:0] pop_cnt;
  logic [CW-1:0] count_nxt;

  // Lanes are used as a prefix, so the set-bit count is the pointer step
  always_comb begin
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < M; i++) begin
      push_cnt = push_cnt + CW'(push[i]);
    end
    for (int j = 0; j < N; j++) begin
      pop_cnt = pop_cnt + CW'(pop[j]);
    end
    count_nxt = count + push_cnt - pop_cnt;
  end

  always_comb begin
    for (int j = 0; j < N; j++) begin
      dataout[j] = mem[AW'(rptr + j)];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < M; i++) begin
      if (push[i]) begin
        mem[AW'(wptr + i)] <= datain[i];
      end
    end
  end

  // Flags come from the next count; full reads high while in reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr         <= '0;
      rptr         <= '0;
      count        <= '0;
      full         <= 1'b1;
      almost_full  <= 1'b1;
      empty        <= 1'b1;
      almost_empty <= 1'b1;
    end else begin
      wptr         <= wptr + AW'(push_cnt);
      rptr         <= rptr + AW'(pop_cnt);
      count        <= count_nxt;
      full         <= (count_nxt == CW'(DEPTH));
      almost_full  <= (count_nxt >= CW'(DEPTH - 1));
      empty        <= (count_nxt == '0);
      almost_empty <= (count_nxt <= CW'(1));
    end
  end

endmodule

// File: hdl/rvv_types_pkg.sv
package rvv_types_pkg;

  import rvv_cfg_pkg::*;

  // Command as issued by the scalar core
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    alu_funct_e            funct;
    logic [VREG_IDX_W-1:0] vd;
    logic [VREG_IDX_W-1:0] vs1;
    logic [VREG_IDX_W-1:0] vs2;
  } rvv_cmd_t;

  // Operands already read, so the station holds everything the ALU needs
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    alu_funct_e           funct;
    logic [VLEN-1:0]      vs1_data;
    logic [VLEN-1:0]      vs2_data;
  } alu_uop_t;

  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [VLEN-1:0]      data;
  } pu2rob_t;

  // ROB entry summary for the dispatch hazard check
  typedef struct packed {
    logic                  valid;
    logic [VREG_IDX_W-1:0] vd;
  } rob_pending_t;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [VREG_IDX_W-1:0] vd;
    logic [VLEN-1:0]       data;
  } rt_data_t;

endpackage

// File: hdl/rvv_cfg_pkg.sv
package rvv_cfg_pkg;

  // Vector shape, SEW 8 and LMUL 1 only
  localparam int VLEN       = 64;
  localparam int SEW        = 8;
  localparam int NUM_ELEM   = VLEN / SEW;
  localparam int NUM_VREG   = 8;
  localparam int VREG_IDX_W = $clog2(NUM_VREG);

  // Intake and queue sizing
  localparam int ISSUE_LANE   = 2;
  localparam int CQ_DEPTH     = 4;
  localparam int ALU_RS_DEPTH = 2;

  // Reorder buffer
  localparam int ROB_DEPTH = 4;
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  localparam int TAG_W = 8;

  typedef enum logic [1:0] {
    FN_ADD,
    FN_SUB,
    FN_AND,
    FN_XOR
  } alu_funct_e;

endpackage
